// ==== rtl/drop_counter.sv ====
// ********************
// saturating total of cells dropped at full queues
// ********************

module drop_counter #(
	parameter int NUM_TILES = 2,
	parameter int DROP_W    = 16
) (
	input  logic                                                        clk_80M,
	input  logic                                                        i_arst_n,
	input  logic [NUM_TILES-1:0][$clog2(gsm_cfg_pkg::TILE_IN+1)-1:0]    i_drop_n,
	output logic [DROP_W-1:0]                                           o_count
);

	logic [DROP_W:0] sum;
	logic [DROP_W:0] next;

	always_comb begin
		sum = '0;
		for (int t = 0; t < NUM_TILES; t++)
			sum = sum + (DROP_W+1)'(i_drop_n[t]);
		next = {1'b0, o_count} + sum;
	end

	// sticks at all ones
	always_ff @(posedge clk_80M or negedge i_arst_n) begin
		if (!i_arst_n)
			o_count <= '0;
		else if (next[DROP_W])
			o_count <= '1;
		else
			o_count <= next[DROP_W-1:0];
	end

endmodule

// ==== rtl/egress_port.sv ====
// ********************
// egress port: round-robin over the tiles and the
// stallable output register
// ********************

module egress_port #(
	parameter int NUM_TILES = 2
) (
	input  logic                                clk_80M,
	input  logic                                i_arst_n,
	input  logic [NUM_TILES-1:0]                i_not_empty,
	input  gsm_cell_pkg::cell_t [NUM_TILES-1:0] i_head,
	input  logic                                i_stall,
	output logic [NUM_TILES-1:0]                o_grant,
	output logic                                o_valid,
	output gsm_cell_pkg::cell_t                 o_data
);

	localparam int TW = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;

	// tile served last, the search starts after it
	logic [TW-1:0] last;
	logic [TW-1:0] sel;
	logic          grant_any;

	// ********************
	// round-robin choice
	// ********************
	always_comb begin
		int idx;
		sel       = last;
		grant_any = 1'b0;
		o_grant   = '0;
		for (int k = 1; k <= NUM_TILES; k++) begin
			idx = (int'(last) + k) % NUM_TILES;
			if (!grant_any && !i_stall && i_not_empty[idx]) begin
				grant_any = 1'b1;
				sel       = TW'(idx);
			end
		end
		if (grant_any)
			o_grant[sel] = 1'b1;
	end

	// ********************
	// output register
	// ********************
	always_ff @(posedge clk_80M or negedge i_arst_n) begin
		if (!i_arst_n) begin
			// tile 0 comes first after reset
			last    <= TW'(NUM_TILES - 1);
			o_valid <= 1'b0;
		end else if (!i_stall) begin
			o_valid <= grant_any;
			if (grant_any)
				last <= sel;
		end
	end

	// loads at the same edge the tile pops its head
	always_ff @(posedge clk_80M) begin
		if (!i_stall && grant_any)
			o_data <= i_head[sel];
	end

endmodule

// ==== rtl/gsm_cell_pkg.sv ====
// ********************
// cell layout: one 32-bit beat, the destination
// egress port in the top bits, payload below
// ********************

package gsm_cell_pkg;

	localparam int CELL_W = 32;
	localparam int DEST_W = 2;

	typedef logic [DEST_W-1:0] port_idx_t;

	typedef struct packed {
		port_idx_t dest;
		logic [CELL_W-DEST_W-1:0] payload;
	} cell_t;

	// destination egress port of a cell
	function automatic port_idx_t cell_dest(input cell_t c);
		return c.dest;
	endfunction

endpackage

// ==== rtl/gsm_cfg_pkg.sv ====
// ********************
// switch configuration: port and tile counts,
// queue depth and the widths derived from them
// ********************

package gsm_cfg_pkg;

	// ingress and egress port count
	localparam int NUM_PORTS = 4;

	// ingress ports are interleaved over the tiles
	localparam int NUM_TILES = 2;
	localparam int TILE_IN = NUM_PORTS / NUM_TILES;

	// cells per egress queue in each tile
	localparam int QDEPTH = 8;

	// queue pointer and occupancy widths
	localparam int QPTR_W = $clog2(QDEPTH);
	localparam int QCNT_W = QPTR_W + 1;

	// running drop total
	localparam int DROP_W = 16;

endpackage

// ==== rtl/gsm_switch.sv ====
// ********************
// grouped shared-memory cell switch, top level:
// ingress ports spread over tiles, one arbiter per
// egress port, global drop total
// ********************

module gsm_switch #(
	parameter int NUM_PORTS = gsm_cfg_pkg::NUM_PORTS,
	parameter int NUM_TILES = gsm_cfg_pkg::NUM_TILES,
	parameter int QDEPTH    = gsm_cfg_pkg::QDEPTH,
	parameter int DROP_W    = gsm_cfg_pkg::DROP_W
) (
	input  logic                                clk_80M,
	input  logic                                i_arst_n,
	input  logic [NUM_PORTS-1:0]                i_ingress_valid,
	input  gsm_cell_pkg::cell_t [NUM_PORTS-1:0] i_ingress_data,
	input  logic [NUM_PORTS-1:0]                i_egress_stall,
	output logic [NUM_PORTS-1:0]                o_egress_valid,
	output gsm_cell_pkg::cell_t [NUM_PORTS-1:0] o_egress_data,
	output logic [DROP_W-1:0]                   o_drop_count
);

	import gsm_cell_pkg::*;

	localparam int TILE_IN = NUM_PORTS / NUM_TILES;
	localparam int DN_W    = $clog2(TILE_IN + 1);

	// tile side, indexed [tile][...]
	logic  [NUM_TILES-1:0][TILE_IN-1:0]   tile_valid;
	cell_t [NUM_TILES-1:0][TILE_IN-1:0]   tile_cell;
	logic  [NUM_TILES-1:0][NUM_PORTS-1:0] tile_not_empty;
	cell_t [NUM_TILES-1:0][NUM_PORTS-1:0] tile_head;
	logic  [NUM_TILES-1:0][NUM_PORTS-1:0] tile_grant;
	logic  [NUM_TILES-1:0][DN_W-1:0]      tile_drop_n;

	// egress side, indexed [port][tile]
	logic  [NUM_PORTS-1:0][NUM_TILES-1:0] eg_not_empty;
	cell_t [NUM_PORTS-1:0][NUM_TILES-1:0] eg_head;
	logic  [NUM_PORTS-1:0][NUM_TILES-1:0] eg_grant;

	// ********************
	// ingress spread
	// ********************
	// port p feeds tile p mod NUM_TILES
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ingress
		assign tile_valid[p % NUM_TILES][p / NUM_TILES] = i_ingress_valid[p];
		assign tile_cell[p % NUM_TILES][p / NUM_TILES]  = i_ingress_data[p];
	end

	for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
		gsm_tile #(
			.TILE_IN   (TILE_IN),
			.NUM_PORTS (NUM_PORTS),
			.QDEPTH    (QDEPTH)
		) u_gsm_tile (
			.clk_80M     (clk_80M),
			.i_arst_n    (i_arst_n),
			.i_valid     (tile_valid[t]),
			.i_cell      (tile_cell[t]),
			.i_grant     (tile_grant[t]),
			.o_not_empty (tile_not_empty[t]),
			.o_head      (tile_head[t]),
			.o_drop_n    (tile_drop_n[t])
		);

		// tile x port transpose
		for (genvar e = 0; e < NUM_PORTS; e++) begin : g_xpose
			assign eg_not_empty[e][t] = tile_not_empty[t][e];
			assign eg_head[e][t]      = tile_head[t][e];
			assign tile_grant[t][e]   = eg_grant[e][t];
		end
	end

	// ********************
	// egress ports
	// ********************
	for (genvar e = 0; e < NUM_PORTS; e++) begin : g_egress
		egress_port #(
			.NUM_TILES (NUM_TILES)
		) u_egress_port (
			.clk_80M     (clk_80M),
			.i_arst_n    (i_arst_n),
			.i_not_empty (eg_not_empty[e]),
			.i_head      (eg_head[e]),
			.i_stall     (i_egress_stall[e]),
			.o_grant     (eg_grant[e]),
			.o_valid     (o_egress_valid[e]),
			.o_data      (o_egress_data[e])
		);
	end

	drop_counter #(
		.NUM_TILES (NUM_TILES),
		.DROP_W    (DROP_W)
	) u_drop_counter (
		.clk_80M  (clk_80M),
		.i_arst_n (i_arst_n),
		.i_drop_n (tile_drop_n),
		.o_count  (o_drop_count)
	);

endmodule

// ==== rtl/gsm_tile.sv ====
// ********************
// one tile: shared cell buffer split into a queue per
// egress port, in-order admission and drop detection
// ********************

module gsm_tile #(
	parameter int TILE_IN   = 2,
	parameter int NUM_PORTS = 4,
	parameter int QDEPTH    = 8
) (
	input  logic                                  clk_80M,
	input  logic                                  i_arst_n,
	input  logic [TILE_IN-1:0]                    i_valid,
	input  gsm_cell_pkg::cell_t [TILE_IN-1:0]     i_cell,
	input  logic [NUM_PORTS-1:0]                  i_grant,
	output logic [NUM_PORTS-1:0]                  o_not_empty,
	output gsm_cell_pkg::cell_t [NUM_PORTS-1:0]   o_head,
	output logic [$clog2(TILE_IN+1)-1:0]          o_drop_n
);

	import gsm_cell_pkg::*;

	localparam int QPTR_W = $clog2(QDEPTH);
	localparam int CNT_W  = QPTR_W + 1;
	localparam int DN_W   = $clog2(TILE_IN + 1);

	logic [NUM_PORTS-1:0][QPTR_W-1:0] wr_ptr0;
	logic [NUM_PORTS-1:0][QPTR_W-1:0] wr_ptr1;
	logic [NUM_PORTS-1:0][QPTR_W-1:0] rd_ptr;
	logic [NUM_PORTS-1:0]             empty;
	logic [NUM_PORTS-1:0][CNT_W-1:0]  free;
	logic [NUM_PORTS-1:0][1:0]        push_n;

	// per ingress cell: accepted, target queue, first or second slot
	logic [TILE_IN-1:0] wr_en;
	port_idx_t          wr_q [TILE_IN];
	logic [TILE_IN-1:0] wr_slot;

	// the shared buffer, statically divided by egress port
	cell_t mem [NUM_PORTS][QDEPTH];

	// ********************
	// admission
	// ********************
	// lower port claims free space first
	always_comb begin
		port_idx_t dest;
		push_n   = '0;
		wr_en    = '0;
		wr_slot  = '0;
		o_drop_n = '0;
		for (int i = 0; i < TILE_IN; i++) begin
			dest       = cell_dest(i_cell[i]);
			wr_q[i]    = dest;
			wr_slot[i] = push_n[dest][0];
			if (i_valid[i]) begin
				if (CNT_W'(push_n[dest]) < free[dest]) begin
					wr_en[i]     = 1'b1;
					push_n[dest] = push_n[dest] + 2'd1;
				end else begin
					o_drop_n = o_drop_n + DN_W'(1);
				end
			end
		end
	end

	// ********************
	// queues and buffer
	// ********************
	for (genvar q = 0; q < NUM_PORTS; q++) begin : g_queue
		queue_ptr #(
			.QDEPTH (QDEPTH),
			.QPTR_W (QPTR_W)
		) u_queue_ptr (
			.clk_80M   (clk_80M),
			.i_arst_n  (i_arst_n),
			.i_push_n  (push_n[q]),
			.i_pop     (i_grant[q]),
			.o_wr_ptr0 (wr_ptr0[q]),
			.o_wr_ptr1 (wr_ptr1[q]),
			.o_rd_ptr  (rd_ptr[q]),
			.o_empty   (empty[q]),
			.o_free    (free[q])
		);

		assign o_not_empty[q] = ~empty[q];
		assign o_head[q]      = mem[q][rd_ptr[q]];
	end

	always_ff @(posedge clk_80M) begin
		for (int i = 0; i < TILE_IN; i++) begin
			if (wr_en[i]) begin
				if (wr_slot[i])
					mem[wr_q[i]][wr_ptr1[wr_q[i]]] <= i_cell[i];
				else
					mem[wr_q[i]][wr_ptr0[wr_q[i]]] <= i_cell[i];
			end
		end
	end

endmodule

// ==== rtl/queue_ptr.sv ====
// ********************
// head/tail pointers and occupancy of one circular
// egress queue, up to two pushes and one pop a cycle
// ********************

module queue_ptr #(
	parameter int QDEPTH = 8,
	parameter int QPTR_W = 3
) (
	input  logic              clk_80M,
	input  logic              i_arst_n,
	input  logic [1:0]        i_push_n,
	input  logic              i_pop,
	output logic [QPTR_W-1:0] o_wr_ptr0,
	output logic [QPTR_W-1:0] o_wr_ptr1,
	output logic [QPTR_W-1:0] o_rd_ptr,
	output logic              o_empty,
	output logic [QPTR_W:0]   o_free
);

	localparam int CNT_W = QPTR_W + 1;

	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0]  cnt;

	// wraps at QDEPTH, which need not be a power of two
	function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] p);
		if (p == QPTR_W'(QDEPTH - 1))
			return '0;
		return p + QPTR_W'(1);
	endfunction

	always_ff @(posedge clk_80M or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			case (i_push_n)
				2'd1: wr_ptr <= ptr_inc(wr_ptr);
				2'd2: wr_ptr <= ptr_inc(ptr_inc(wr_ptr));
				default: wr_ptr <= wr_ptr;
			endcase
			if (i_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			cnt <= cnt + CNT_W'(i_push_n) - CNT_W'(i_pop);
		end
	end

	// second push lands one slot after the first
	assign o_wr_ptr0 = wr_ptr;
	assign o_wr_ptr1 = ptr_inc(wr_ptr);
	assign o_rd_ptr  = rd_ptr;
	assign o_empty   = (cnt == '0);
	assign o_free    = CNT_W'(QDEPTH) - cnt;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gsm_switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_gsm_switch \
	--Mdir "$OBJ" -o tb_gsm_switch
status=$?
if [ "$status" -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$OBJ/tb_gsm_switch" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sources.f ====
rtl/gsm_cfg_pkg.sv
rtl/gsm_cell_pkg.sv
rtl/queue_ptr.sv
rtl/gsm_tile.sv
rtl/egress_port.sv
rtl/drop_counter.sv
rtl/gsm_switch.sv
test/tb_gsm_switch.sv

// ==== test/tb_gsm_switch.sv ====
// ********************
// testbench for the grouped shared-memory switch
// with reference queues per tile and egress port
// and assertions on every transfer
// ********************

module tb_gsm_switch;

	timeunit 1ns;
	timeprecision 1ps;

	import gsm_cfg_pkg::*;
	import gsm_cell_pkg::*;

	localparam int CLK_NS     = 10;
	localparam int RST_CYC    = 5;
	localparam int FAIR_CYC   = 3;
	localparam int DROP_K     = 3;
	localparam int DROP_N     = QDEPTH + DROP_K;
	localparam int RAND_CYC   = 400;
	localparam int STIM_CYC   = RST_CYC + FAIR_CYC + DROP_N + RAND_CYC;
	localparam int TIMEOUT_NS = STIM_CYC * 4 * CLK_NS + 1000;
	localparam logic [31:0] SEED = 32'hcad9_5fa3;
	// payload starts with the source port
	localparam int SRC_LSB    = CELL_W - 2 * DEST_W;

	logic                  clk_80M;
	logic                  i_arst_n;
	logic  [NUM_PORTS-1:0] i_ingress_valid;
	cell_t [NUM_PORTS-1:0] i_ingress_data;
	logic  [NUM_PORTS-1:0] i_egress_stall;
	logic  [NUM_PORTS-1:0] o_egress_valid;
	cell_t [NUM_PORTS-1:0] o_egress_data;
	logic  [DROP_W-1:0]    o_drop_count;

	// reference model
	cell_t ref_q [NUM_TILES][NUM_PORTS][$];
	int    seq [NUM_PORTS] = '{default: 0};
	int    drop_total = 0;

	// model state seen by the assertions, updated with NBA
	int                    cyc = 0;
	cell_t                 front [NUM_TILES][NUM_PORTS];
	logic                  front_ok [NUM_TILES][NUM_PORTS];
	int                    last_src [NUM_PORTS] = '{default: 0};
	int                    xfer_cnt [NUM_PORTS] = '{default: 0};
	logic  [DROP_W-1:0]    exp_drops = '0;
	logic  [NUM_PORTS-1:0] prev_valid = '0;
	logic  [NUM_PORTS-1:0] prev_stall = '0;
	cell_t [NUM_PORTS-1:0] prev_data;
	logic                  prev_rst_n = 1'b0;
	cell_t                 exp_cell [NUM_PORTS];
	logic                  exp_ok [NUM_PORTS];
	logic                  fair_on;
	int                    fair_base;

	gsm_switch i_gsm_switch (
		.clk_80M         (clk_80M),
		.i_arst_n        (i_arst_n),
		.i_ingress_valid (i_ingress_valid),
		.i_ingress_data  (i_ingress_data),
		.i_egress_stall  (i_egress_stall),
		.o_egress_valid  (o_egress_valid),
		.o_egress_data   (o_egress_data),
		.o_drop_count    (o_drop_count)
	);

	// ********************
	// helpers
	// ********************
	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("mismatch %s: expected %h, actual %h", name, exp_v, act_v);
		abort_run();
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		abort_run();
	endtask

	function automatic int src_tile(input cell_t c);
		return int'(c[SRC_LSB +: DEST_W]) % NUM_TILES;
	endfunction

	// dest, source port, random filler, sequence number
	function automatic cell_t make_cell(input int src, input int dest);
		cell_t c;
		c = {DEST_W'(dest), DEST_W'(src), 12'($urandom), 16'(seq[src])};
		seq[src]++;
		return c;
	endfunction

	function automatic int pending_cells();
		int n;
		n = 0;
		for (int t = 0; t < NUM_TILES; t++)
			for (int e = 0; e < NUM_PORTS; e++)
				n += ref_q[t][e].size();
		return n;
	endfunction

	task automatic drive_cycle(input logic [NUM_PORTS-1:0] vld,
			input logic [NUM_PORTS-1:0][DEST_W-1:0] dst, input logic [NUM_PORTS-1:0] stl);
		@(posedge clk_80M);
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (vld[p])
				i_ingress_data[p] <= make_cell(p, int'(dst[p]));
			else
				i_ingress_data[p] <= '0;
		end
		i_ingress_valid <= vld;
		i_egress_stall  <= stl;
	endtask

	task automatic wait_drain();
		do
			@(negedge clk_80M);
		while (pending_cells() != 0);
	endtask

	// two quiet cycles in a row end the burst on a port
	task automatic wait_port_idle(input int port);
		int quiet;
		quiet = 0;
		while (quiet < 2) begin
			@(negedge clk_80M);
			if (o_egress_valid[port])
				quiet = 0;
			else
				quiet++;
		end
	endtask

	// ********************
	// reference model
	// ********************
	always @(posedge clk_80M) begin
		int        t;
		int        held [NUM_TILES][NUM_PORTS];
		int        added [NUM_TILES][NUM_PORTS];
		port_idx_t d;
		cyc        <= cyc + 1;
		prev_valid <= o_egress_valid;
		prev_stall <= i_egress_stall;
		prev_data  <= o_egress_data;
		prev_rst_n <= i_arst_n;
		if (!i_arst_n) begin
			drop_total = 0;
			for (int a = 0; a < NUM_TILES; a++)
				for (int e = 0; e < NUM_PORTS; e++)
					ref_q[a][e].delete();
		end else begin
			// tile queue holds everything except the cell in the output register
			for (int a = 0; a < NUM_TILES; a++) begin
				for (int e = 0; e < NUM_PORTS; e++) begin
					held[a][e]  = ref_q[a][e].size();
					added[a][e] = 0;
				end
			end
			for (int e = 0; e < NUM_PORTS; e++) begin
				t = src_tile(o_egress_data[e]);
				if (o_egress_valid[e] && held[t][e] > 0)
					held[t][e]--;
			end
			for (int e = 0; e < NUM_PORTS; e++) begin
				if (o_egress_valid[e] && !i_egress_stall[e]) begin
					t = src_tile(o_egress_data[e]);
					if (ref_q[t][e].size() != 0)
						void'(ref_q[t][e].pop_front());
					last_src[e] <= t;
					xfer_cnt[e] <= xfer_cnt[e] + 1;
				end
			end
			// lower port of a tile is admitted first
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (i_ingress_valid[p]) begin
					t = p % NUM_TILES;
					d = i_ingress_data[p][CELL_W-1 -: DEST_W];
					if (held[t][d] + added[t][d] < QDEPTH) begin
						ref_q[t][d].push_back(i_ingress_data[p]);
						added[t][d]++;
					end else begin
						drop_total++;
					end
				end
			end
		end
		for (int a = 0; a < NUM_TILES; a++) begin
			for (int e = 0; e < NUM_PORTS; e++) begin
				front[a][e]    <= (ref_q[a][e].size() != 0) ? ref_q[a][e][0] : '0;
				front_ok[a][e] <= (ref_q[a][e].size() != 0);
			end
		end
		exp_drops <= DROP_W'(drop_total);
	end

	// expected head for the cell now on each output
	always_comb begin
		int t;
		for (int e = 0; e < NUM_PORTS; e++) begin
			t           = src_tile(o_egress_data[e]);
			exp_cell[e] = front[t][e];
			exp_ok[e]   = front_ok[t][e];
		end
	end

	// ********************
	// assertions
	// ********************
	assert property (@(posedge clk_80M) (cyc > 0 && (!i_arst_n || !prev_rst_n))
			|-> o_egress_valid == '0)
		else report_mismatch("reset valid", '0, 32'($sampled(o_egress_valid)));

	assert property (@(posedge clk_80M) (cyc > 0 && (!i_arst_n || !prev_rst_n))
			|-> o_drop_count == '0)
		else report_mismatch("reset drop count", '0, 32'($sampled(o_drop_count)));

	assert property (@(posedge clk_80M) disable iff (!i_arst_n) o_drop_count == exp_drops)
		else report_mismatch("drop count", $sampled(exp_drops), $sampled(o_drop_count));

	for (genvar e = 0; e < NUM_PORTS; e++) begin : g_check
		assert property (@(posedge clk_80M) disable iff (!i_arst_n)
				(o_egress_valid[e] && !i_egress_stall[e]) |-> exp_ok[e])
			else report_failure($sformatf("port %0d sent a cell that was never admitted", e));

		assert property (@(posedge clk_80M) disable iff (!i_arst_n)
				(o_egress_valid[e] && !i_egress_stall[e]) |-> o_egress_data[e] == exp_cell[e])
			else report_mismatch($sformatf("routing port %0d", e), $sampled(exp_cell[e]),
				$sampled(o_egress_data[e]));

		assert property (@(posedge clk_80M) disable iff (!i_arst_n)
				(prev_rst_n && prev_stall[e]) |-> o_egress_valid[e] == prev_valid[e])
			else report_mismatch($sformatf("stall valid port %0d", e),
				32'($sampled(prev_valid[e])), 32'($sampled(o_egress_valid[e])));

		assert property (@(posedge clk_80M) disable iff (!i_arst_n)
				(prev_rst_n && prev_stall[e] && prev_valid[e]) |-> o_egress_data[e] == prev_data[e])
			else report_mismatch($sformatf("stall data port %0d", e), $sampled(prev_data[e]),
				$sampled(o_egress_data[e]));
	end

	// back-to-back service on port 0 switches tiles
	assert property (@(posedge clk_80M) disable iff (!i_arst_n)
			(fair_on && o_egress_valid[0] && !i_egress_stall[0] && xfer_cnt[0] != fair_base)
			|-> src_tile(o_egress_data[0]) != last_src[0])
		else report_mismatch("fairness", 32'(($sampled(last_src[0]) + 1) % NUM_TILES),
			32'(src_tile($sampled(o_egress_data[0]))));

	// ********************
	// clock, watchdog, stimulus
	// ********************
	initial begin
		clk_80M = 1'b0;
		forever #(CLK_NS / 2) clk_80M = ~clk_80M;
	end

	initial begin
		#(TIMEOUT_NS);
		report_failure("timeout: the switch did not deliver all admitted cells in time");
	end

	initial begin
		logic [NUM_PORTS-1:0]             vld;
		logic [NUM_PORTS-1:0][DEST_W-1:0] dst;
		logic [NUM_PORTS-1:0]             stl;
		logic [DROP_W-1:0]                base_drops;
		int                               base_xfer;
		void'($urandom(SEED));
		i_arst_n        = 1'b0;
		i_ingress_valid = '0;
		i_ingress_data  = '0;
		i_egress_stall  = '0;
		fair_on         = 1'b0;
		fair_base       = 0;
		repeat (RST_CYC) @(posedge clk_80M);
		i_arst_n <= 1'b1;

		// every port loads egress 0 while it is stalled
		drive_cycle('0, '0, 4'b0001);
		repeat (FAIR_CYC) drive_cycle('1, '0, 4'b0001);
		drive_cycle('0, '0, 4'b0001);
		@(negedge clk_80M);
		fair_base = xfer_cnt[0];
		fair_on   = 1'b1;
		drive_cycle('0, '0, '0);
		wait_drain();
		fair_on = 1'b0;

		// port 2 floods stalled egress 3
		dst    = '0;
		dst[2] = DEST_W'(3);
		drive_cycle('0, '0, 4'b1000);
		@(negedge clk_80M);
		base_drops = o_drop_count;
		repeat (DROP_N) drive_cycle(4'b0100, dst, 4'b1000);
		drive_cycle('0, '0, 4'b1000);
		@(negedge clk_80M);
		assert (o_drop_count - base_drops == DROP_W'(DROP_K))
			else report_mismatch("drops", 32'(base_drops) + DROP_K, 32'(o_drop_count));
		base_xfer = xfer_cnt[3];
		drive_cycle('0, '0, '0);
		wait_port_idle(3);
		assert (xfer_cnt[3] - base_xfer == QDEPTH)
			else report_mismatch("drop drain", QDEPTH, xfer_cnt[3] - base_xfer);

		// random traffic with random stalls
		for (int c = 0; c < RAND_CYC; c++) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				vld[p] = $urandom % 2;
				dst[p] = DEST_W'($urandom % NUM_PORTS);
				stl[p] = ($urandom % 4) == 0;
			end
			drive_cycle(vld, dst, stl);
		end
		drive_cycle('0, '0, '0);
		wait_drain();
		assert (o_egress_valid == '0)
			else report_failure("an output is still valid after all cells were delivered");
		assert (o_drop_count == DROP_W'(drop_total))
			else report_mismatch("random drop total", drop_total, 32'(o_drop_count));

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
